/* Bender.yml */
package:
  name: alu_pipe

sources:
  - source/alu_pkg.sv
  - source/alu_lane_adder.sv
  - source/alu_lane_shifter.sv
  - source/alu_lane_compare.sv
  - source/alu_decode_stage.sv
  - source/alu_execute_stage.sv
  - source/alu_result_stage.sv
  - source/alu_pipe_top.sv
  - target: test
    files:
      - verif/tb_alu_pipe.sv

/* source/alu_decode_stage.sv */
// decode stage: opcode to control field translation and the first pipeline register
`timescale 1ns/1ps

module alu_decode_stage (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                enable_i,
  input  alu_pkg::alu_op_e    operator_i,
  input  alu_pkg::vec_mode_e  vector_mode_i,
  input  alu_pkg::word_t      operand_a_i,
  input  alu_pkg::word_t      operand_b_i,
  output alu_pkg::dec_stage_t dec_o
);
  import alu_pkg::*;

  alu_ctrl_t ctrl_d;
  // op treats the top bit of each lane as a sign
  logic      is_signed;

  ////////////////////////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_d              = '0;
    ctrl_d.mode         = vector_mode_i;
    ctrl_d.res_sel      = SEL_ADD;
    ctrl_d.cmp_cond     = CMP_EQ;
    is_signed           = 1'b0;
    case (operator_i)
      ALU_ADD: ctrl_d.res_sel = SEL_ADD;
      ALU_SUB: ctrl_d.negate_b = 1'b1;
      ALU_AND: ctrl_d.res_sel = SEL_AND;
      ALU_OR:  ctrl_d.res_sel = SEL_OR;
      ALU_XOR: ctrl_d.res_sel = SEL_XOR;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR: begin
        ctrl_d.res_sel     = SEL_SHIFT;
        ctrl_d.shift_left  = (operator_i == ALU_SLL);
        ctrl_d.shift_arith = (operator_i == ALU_SRA);
        // only honoured in 32-bit mode
        ctrl_d.rotate      = (operator_i == ALU_ROR);
      end
      ALU_EQ, ALU_NE, ALU_GTS, ALU_GES, ALU_LTS, ALU_LES,
      ALU_GTU, ALU_GEU, ALU_LTU, ALU_LEU: begin
        ctrl_d.res_sel  = SEL_CMP_VEC;
        ctrl_d.negate_b = 1'b1;
        is_signed       = (operator_i inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES});
        case (operator_i)
          ALU_NE:           ctrl_d.cmp_cond = CMP_NE;
          ALU_GTS, ALU_GTU: ctrl_d.cmp_cond = CMP_GT;
          ALU_GES, ALU_GEU: ctrl_d.cmp_cond = CMP_GE;
          ALU_LTS, ALU_LTU: ctrl_d.cmp_cond = CMP_LT;
          ALU_LES, ALU_LEU: ctrl_d.cmp_cond = CMP_LE;
          default:          ctrl_d.cmp_cond = CMP_EQ;
        endcase
      end
      ALU_SLTS, ALU_SLTU: begin
        ctrl_d.res_sel  = SEL_CMP_SCALAR;
        ctrl_d.negate_b = 1'b1;
        ctrl_d.cmp_cond = CMP_LT;
        is_signed       = (operator_i == ALU_SLTS);
      end
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: begin
        ctrl_d.res_sel  = SEL_MINMAX;
        ctrl_d.negate_b = 1'b1;
        ctrl_d.do_min   = (operator_i == ALU_MIN) || (operator_i == ALU_MINU);
        is_signed       = (operator_i == ALU_MIN) || (operator_i == ALU_MAX);
      end
      default: ctrl_d.res_sel = SEL_ADD;
    endcase
    // sign bit sits in the top byte of each lane
    if (is_signed) begin
      case (vector_mode_i)
        VEC_MODE8:  ctrl_d.signed_lanes = 4'b1111;
        VEC_MODE16: ctrl_d.signed_lanes = 4'b1010;
        default:    ctrl_d.signed_lanes = 4'b1000;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= enable_i;
    end
    // payload only moves on an issue
    if (enable_i) begin
      dec_o.ctrl <= ctrl_d;
      dec_o.op_a <= operand_a_i;
      dec_o.op_b <= operand_b_i;
    end
  end

endmodule

/* source/alu_execute_stage.sv */
// execute stage: adder, shifter and comparator with the second pipeline register
`timescale 1ns/1ps

module alu_execute_stage (
  input  logic                clk,
  input  logic                rst_n_i,
  input  alu_pkg::dec_stage_t dec_i,
  output alu_pkg::exe_stage_t exe_o
);
  import alu_pkg::*;

  word_t      add_res;
  word_t      shift_res;
  lane_mask_t lane_eq;
  lane_mask_t lane_gt;

  alu_lane_adder u_adder (
    .op_a_i (dec_i.op_a),
    .op_b_i (dec_i.op_b),
    .ctrl_i (dec_i.ctrl),
    .sum_o  (add_res)
  );

  alu_lane_shifter u_shifter (
    .op_a_i  (dec_i.op_a),
    .op_b_i  (dec_i.op_b),
    .ctrl_i  (dec_i.ctrl),
    .shift_o (shift_res)
  );

  alu_lane_compare u_compare (
    .op_a_i    (dec_i.op_a),
    .op_b_i    (dec_i.op_b),
    .ctrl_i    (dec_i.ctrl),
    .lane_eq_o (lane_eq),
    .lane_gt_o (lane_gt)
  );

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      exe_o.valid <= 1'b0;
    end else begin
      exe_o.valid <= dec_i.valid;
    end
    // operands ride along for logic ops and min/max
    if (dec_i.valid) begin
      exe_o.ctrl      <= dec_i.ctrl;
      exe_o.op_a      <= dec_i.op_a;
      exe_o.op_b      <= dec_i.op_b;
      exe_o.add_res   <= add_res;
      exe_o.shift_res <= shift_res;
      exe_o.lane_eq   <= lane_eq;
      exe_o.lane_gt   <= lane_gt;
    end
  end

endmodule

/* source/alu_lane_adder.sv */
// lane-partitioned 32-bit adder with carry separator bits between the bytes
`timescale 1ns/1ps

module alu_lane_adder (
  input  alu_pkg::word_t     op_a_i,
  input  alu_pkg::word_t     op_b_i,
  input  alu_pkg::alu_ctrl_t ctrl_i,
  output alu_pkg::word_t     sum_o
);
  import alu_pkg::*;

  word_t       op_b;
  // bytes interleaved with separator bits at 0, 9, 18 and 27
  logic [35:0] in_a;
  logic [35:0] in_b;
  logic [35:0] sum_wide;

  // two's complement subtract, carry-in comes from the separators
  assign op_b = ctrl_i.negate_b ? ~op_b_i : op_b_i;

  always_comb begin
    in_a = {op_a_i[31:24], 1'b1, op_a_i[23:16], 1'b1, op_a_i[15:8], 1'b1, op_a_i[7:0], 1'b1};
    in_b = {op_b[31:24], 1'b0, op_b[23:16], 1'b0, op_b[15:8], 1'b0, op_b[7:0], 1'b0};
    if (ctrl_i.negate_b) begin
      // 1+1 at a separator always carries a one into the lane above
      in_b[0] = 1'b1;
      case (ctrl_i.mode)
        VEC_MODE16: in_b[18] = 1'b1;
        VEC_MODE8: begin
          in_b[9]  = 1'b1;
          in_b[18] = 1'b1;
          in_b[27] = 1'b1;
        end
        // 32-bit mode needs only the lane 0 carry-in
        default: ;
      endcase
    end else begin
      // 0+0 at a separator kills the carry at the lane boundary
      case (ctrl_i.mode)
        VEC_MODE16: in_a[18] = 1'b0;
        VEC_MODE8: begin
          in_a[9]  = 1'b0;
          in_a[18] = 1'b0;
          in_a[27] = 1'b0;
        end
        // 32-bit mode lets every separator pass the carry
        default: ;
      endcase
    end
  end

  assign sum_wide = in_a + in_b;

  // drop the separators again
  assign sum_o = {sum_wide[35:28], sum_wide[26:19], sum_wide[17:10], sum_wide[8:1]};

endmodule

/* source/alu_lane_compare.sv */
// byte equal and greater-than cells chained into lane compare results by vector mode
`timescale 1ns/1ps

module alu_lane_compare (
  input  alu_pkg::word_t     op_a_i,
  input  alu_pkg::word_t     op_b_i,
  input  alu_pkg::alu_ctrl_t ctrl_i,
  output alu_pkg::lane_mask_t lane_eq_o,
  output alu_pkg::lane_mask_t lane_gt_o
);
  import alu_pkg::*;

  lane_mask_t byte_eq;
  lane_mask_t byte_gt;
  logic       eq32;
  logic       gt32;

  ////////////////////////////////////////////////////////////
  // byte cells
  ////////////////////////////////////////////////////////////

  // 9-bit compare, the extra bit is the sign when the byte holds one
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      byte_eq[i] = (op_a_i[8*i +: 8] == op_b_i[8*i +: 8]);
      byte_gt[i] = $signed({op_a_i[8*i+7] & ctrl_i.signed_lanes[i], op_a_i[8*i +: 8]}) >
                   $signed({op_b_i[8*i+7] & ctrl_i.signed_lanes[i], op_b_i[8*i +: 8]});
    end
  end

  ////////////////////////////////////////////////////////////
  // lane combine
  ////////////////////////////////////////////////////////////

  // top byte decides unless equal, then the next one down
  assign eq32 = &byte_eq;
  assign gt32 = byte_gt[3] | (byte_eq[3] & (byte_gt[2] |
                (byte_eq[2] & (byte_gt[1] | (byte_eq[1] & byte_gt[0])))));

  always_comb begin
    case (ctrl_i.mode)
      VEC_MODE16: begin
        lane_eq_o[3:2] = {2{byte_eq[3] & byte_eq[2]}};
        lane_eq_o[1:0] = {2{byte_eq[1] & byte_eq[0]}};
        lane_gt_o[3:2] = {2{byte_gt[3] | (byte_eq[3] & byte_gt[2])}};
        lane_gt_o[1:0] = {2{byte_gt[1] | (byte_eq[1] & byte_gt[0])}};
      end
      VEC_MODE8: begin
        lane_eq_o = byte_eq;
        lane_gt_o = byte_gt;
      end
      default: begin
        // one lane, replicated over all four bytes
        lane_eq_o = {4{eq32}};
        lane_gt_o = {4{gt32}};
      end
    endcase
  end

endmodule

/* source/alu_lane_shifter.sv */
// per-lane right shifter with bit reversal for left shifts and 32-bit rotate
`timescale 1ns/1ps

module alu_lane_shifter (
  input  alu_pkg::word_t     op_a_i,
  input  alu_pkg::word_t     op_b_i,
  input  alu_pkg::alu_ctrl_t ctrl_i,
  output alu_pkg::word_t     shift_o
);
  import alu_pkg::*;

  word_t           a_rev;
  word_t           amt_left;
  word_t           shift_in;
  word_t           amt;
  word_t           right_res;
  logic [63:0]     ext32;
  logic [63:0]     right32;
  logic [1:0][16:0] right16;
  logic [3:0][8:0] right8;

  // left shift is a right shift of the reversed word
  always_comb begin
    for (int k = 0; k < 32; k++) begin
      a_rev[k] = op_a_i[31-k];
    end
  end

  // reversing the word also reverses the lane order of the amounts
  always_comb begin
    case (ctrl_i.mode)
      VEC_MODE16: amt_left = {op_b_i[15:0], op_b_i[31:16]};
      VEC_MODE8:  amt_left = {op_b_i[7:0], op_b_i[15:8], op_b_i[23:16], op_b_i[31:24]};
      default:    amt_left = op_b_i;
    endcase
  end

  assign shift_in = ctrl_i.shift_left ? a_rev : op_a_i;
  assign amt      = ctrl_i.shift_left ? amt_left : op_b_i;

  always_comb begin
    // 32-bit: doubled word for rotate, else sign or zero fill
    ext32   = ctrl_i.rotate ? {shift_in, shift_in} :
                              {{32{ctrl_i.shift_arith & shift_in[31]}}, shift_in};
    right32 = ext32 >> amt[4:0];
    // 16-bit lanes use 4 amount bits
    for (int i = 0; i < 2; i++) begin
      right16[i] = $signed({ctrl_i.shift_arith & shift_in[16*i+15], shift_in[16*i +: 16]})
                   >>> amt[16*i +: 4];
    end
    // 8-bit lanes use 3 amount bits
    for (int i = 0; i < 4; i++) begin
      right8[i] = $signed({ctrl_i.shift_arith & shift_in[8*i+7], shift_in[8*i +: 8]})
                  >>> amt[8*i +: 3];
    end
    case (ctrl_i.mode)
      VEC_MODE16: right_res = {right16[1][15:0], right16[0][15:0]};
      VEC_MODE8:  right_res = {right8[3][7:0], right8[2][7:0], right8[1][7:0], right8[0][7:0]};
      default:    right_res = right32[31:0];
    endcase
  end

  // undo the reversal for left shifts
  always_comb begin
    for (int k = 0; k < 32; k++) begin
      shift_o[k] = ctrl_i.shift_left ? right_res[31-k] : right_res[k];
    end
  end

endmodule

/* source/alu_pipe_top.sv */
// top level of the three-stage packed-SIMD ALU pipeline
`timescale 1ns/1ps

module alu_pipe_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               enable_i,
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::vec_mode_e vector_mode_i,
  input  alu_pkg::word_t     operand_a_i,
  input  alu_pkg::word_t     operand_b_i,
  output alu_pkg::word_t     result_o,
  output logic               comparison_result_o,
  output logic               result_valid_o
);
  import alu_pkg::*;

  // stage registers between decode, execute and result
  dec_stage_t dec;
  exe_stage_t exe;

  alu_decode_stage u_decode (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .enable_i      (enable_i),
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .dec_o         (dec)
  );

  alu_execute_stage u_execute (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .dec_i   (dec),
    .exe_o   (exe)
  );

  alu_result_stage u_result (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .exe_i               (exe),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .result_valid_o      (result_valid_o)
  );

endmodule

/* source/alu_pkg.sv */
// word and lane typedefs, opcode, mode, select and condition enums, pipeline stage structs
package alu_pkg;

  // data word and per-byte lane flags, bit 3 is the top byte
  typedef logic [31:0] word_t;
  typedef logic [3:0]  lane_mask_t;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR,
    ALU_EQ, ALU_NE,
    ALU_GTS, ALU_GES, ALU_LTS, ALU_LES,
    ALU_GTU, ALU_GEU, ALU_LTU, ALU_LEU,
    ALU_SLTS, ALU_SLTU,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU
  } alu_op_e;

  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // unit that supplies the final result
  typedef enum logic [2:0] {
    SEL_ADD, SEL_SHIFT, SEL_AND, SEL_OR, SEL_XOR,
    SEL_CMP_VEC, SEL_CMP_SCALAR, SEL_MINMAX
  } res_sel_e;

  typedef enum logic [2:0] {
    CMP_EQ, CMP_NE, CMP_GT, CMP_GE, CMP_LT, CMP_LE
  } cmp_cond_e;

  // decoded control, 17 bits
  typedef struct packed {
    vec_mode_e  mode;
    res_sel_e   res_sel;
    cmp_cond_e  cmp_cond;
    logic       negate_b;
    lane_mask_t signed_lanes;
    logic       shift_left;
    logic       shift_arith;
    logic       rotate;
    logic       do_min;
  } alu_ctrl_t;

  typedef struct packed {
    logic      valid;
    alu_ctrl_t ctrl;
    word_t     op_a;
    word_t     op_b;
  } dec_stage_t;

  typedef struct packed {
    logic       valid;
    alu_ctrl_t  ctrl;
    word_t      op_a;
    word_t      op_b;
    word_t      add_res;
    word_t      shift_res;
    lane_mask_t lane_eq;
    lane_mask_t lane_gt;
  } exe_stage_t;

endpackage

/* source/alu_result_stage.sv */
// result stage: compare condition, min/max, logic ops and the registered result mux
`timescale 1ns/1ps

module alu_result_stage (
  input  logic                clk,
  input  logic                rst_n_i,
  input  alu_pkg::exe_stage_t exe_i,
  output alu_pkg::word_t      result_o,
  output logic                comparison_result_o,
  output logic                result_valid_o
);
  import alu_pkg::*;

  lane_mask_t cmp_res;
  lane_mask_t sel_a;
  word_t      minmax_res;
  word_t      result_d;

  // condition applied per lane
  always_comb begin
    case (exe_i.ctrl.cmp_cond)
      CMP_NE:  cmp_res = ~exe_i.lane_eq;
      CMP_GT:  cmp_res = exe_i.lane_gt;
      CMP_GE:  cmp_res = exe_i.lane_gt | exe_i.lane_eq;
      CMP_LT:  cmp_res = ~(exe_i.lane_gt | exe_i.lane_eq);
      CMP_LE:  cmp_res = ~exe_i.lane_gt;
      default: cmp_res = exe_i.lane_eq;
    endcase
  end

  // max keeps a when greater, min when not
  assign sel_a = exe_i.lane_gt ^ {4{exe_i.ctrl.do_min}};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      minmax_res[8*i +: 8] = sel_a[i] ? exe_i.op_a[8*i +: 8] : exe_i.op_b[8*i +: 8];
    end
  end

  ////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (exe_i.ctrl.res_sel)
      SEL_SHIFT:      result_d = exe_i.shift_res;
      SEL_AND:        result_d = exe_i.op_a & exe_i.op_b;
      SEL_OR:         result_d = exe_i.op_a | exe_i.op_b;
      SEL_XOR:        result_d = exe_i.op_a ^ exe_i.op_b;
      // each byte is all ones or all zeros
      SEL_CMP_VEC:    result_d = {{8{cmp_res[3]}}, {8{cmp_res[2]}},
                                  {8{cmp_res[1]}}, {8{cmp_res[0]}}};
      SEL_CMP_SCALAR: result_d = {31'b0, cmp_res[3]};
      SEL_MINMAX:     result_d = minmax_res;
      default:        result_d = exe_i.add_res;
    endcase
  end

  // outputs hold their last value on idle cycles
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= exe_i.valid;
    end
    if (exe_i.valid) begin
      result_o            <= result_d;
      comparison_result_o <= cmp_res[3];
    end
  end

endmodule

/* src.f */
source/alu_pkg.sv
source/alu_lane_adder.sv
source/alu_lane_shifter.sv
source/alu_lane_compare.sv
source/alu_decode_stage.sv
source/alu_execute_stage.sv
source/alu_result_stage.sv
source/alu_pipe_top.sv
verif/tb_alu_pipe.sv

/* verif/tb_alu_pipe.sv */
// directed testbench for the packed-SIMD ALU pipeline: reference model, checks, tests, timeout
`timescale 1ns/1ps

module tb_alu_pipe;
  import alu_pkg::*;

  // upper bound on issued operations over all tests
  localparam int NUM_OPS    = 479;
  localparam int MAX_CYCLES = NUM_OPS * 4 + 10 + 100;

  // one expected result, waiting for its valid pulse
  typedef struct packed {
    alu_op_e     op;
    vec_mode_e   mode;
    word_t       res;
    logic        cmp;
    logic        chk_cmp;
    logic [31:0] due;
  } exp_t;

  logic      clk;
  logic      rst_n_i;
  logic      enable_i;
  alu_op_e   operator_i;
  vec_mode_e vector_mode_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  word_t     result_o;
  logic      comparison_result_o;
  logic      result_valid_o;

  exp_t   exp_q[$];
  integer seed = 73;
  int     cyc = 0;
  int     errors = 0;
  int     checks = 0;
  int     tests_ok = 0;
  int     tests_bad = 0;

  alu_pipe_top UUT (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .enable_i            (enable_i),
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .result_valid_o      (result_valid_o)
  );

  always #5 clk = ~clk;

  // cycle count, also ends a hung run
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // returns {top-lane compare, result}, lane by lane
  function automatic logic [32:0] ref_alu(alu_op_e op, vec_mode_e mode, word_t a, word_t b);
    int          w;
    int          sh;
    logic [63:0] mask;
    longint      la;
    longint      lb;
    longint      sa;
    longint      sb;
    longint      ca;
    longint      cb;
    longint      r;
    logic        hit;
    logic        sgn;
    word_t       res;
    w    = (mode == VEC_MODE8) ? 8 : (mode == VEC_MODE16) ? 16 : 32;
    mask = (64'd1 << w) - 1;
    res  = '0;
    hit  = 1'b0;
    sgn  = op inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS, ALU_MIN, ALU_MAX};
    for (int i = 0; i < 32 / w; i++) begin
      la = longint'((64'(a) >> (i * w)) & mask);
      lb = longint'((64'(b) >> (i * w)) & mask);
      // sign-extended lane values
      sa = la[w-1] ? la - (longint'(1) << w) : la;
      sb = lb[w-1] ? lb - (longint'(1) << w) : lb;
      ca = sgn ? sa : la;
      cb = sgn ? sb : lb;
      // amount is the low log2(w) bits of the same lane of b
      sh = int'(lb) & (w - 1);
      r  = 0;
      case (op)
        ALU_ADD:  r = la + lb;
        ALU_SUB:  r = la - lb;
        ALU_AND:  r = la & lb;
        ALU_OR:   r = la | lb;
        ALU_XOR:  r = la ^ lb;
        ALU_SLL:  r = la << sh;
        ALU_SRL:  r = la >> sh;
        ALU_SRA:  r = sa >>> sh;
        // rotate only in 32-bit mode, plain logical shift per lane otherwise
        ALU_ROR:  r = (w == 32) ? ((la >> sh) | (la << (32 - sh))) : (la >> sh);
        ALU_EQ:   hit = (ca == cb);
        ALU_NE:   hit = (ca != cb);
        ALU_GTS, ALU_GTU: hit = (ca > cb);
        ALU_GES, ALU_GEU: hit = (ca >= cb);
        ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: hit = (ca < cb);
        ALU_LES, ALU_LEU: hit = (ca <= cb);
        ALU_MIN, ALU_MINU: r = (ca < cb) ? la : lb;
        ALU_MAX, ALU_MAXU: r = (ca > cb) ? la : lb;
        default:  r = 0;
      endcase
      // vector compares fill the lane
      if (op inside {[ALU_EQ:ALU_LEU]}) begin
        r = hit ? -1 : 0;
      end
      res = res | word_t'((64'(r) & mask) << (i * w));
    end
    // loop ends on the top lane, so hit is its compare
    if (op inside {ALU_SLTS, ALU_SLTU}) begin
      res = {31'b0, hit};
    end
    return {hit, res};
  endfunction

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic compare_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic vec_mode_e pick_mode(int k);
    case (k % 3)
      1:       return VEC_MODE16;
      2:       return VEC_MODE8;
      default: return VEC_MODE32;
    endcase
  endfunction

  function automatic word_t rnd_word();
    return word_t'($random(seed));
  endfunction

  // drives one op on the next edge and queues its expected result
  task automatic issue_op(input alu_op_e op, input vec_mode_e mode, input word_t a,
                          input word_t b);
    exp_t        e;
    logic [32:0] r;
    @(posedge clk);
    enable_i      <= 1'b1;
    operator_i    <= op;
    vector_mode_i <= mode;
    operand_a_i   <= a;
    operand_b_i   <= b;
    r         = ref_alu(op, mode, a, b);
    e.op      = op;
    e.mode    = mode;
    e.res     = r[31:0];
    e.cmp     = r[32];
    e.chk_cmp = op inside {[ALU_EQ:ALU_SLTU]};
    // pulse seen at the negedge after the third edge
    e.due     = cyc + 4;
    exp_q.push_back(e);
  endtask

  task automatic go_idle();
    @(posedge clk);
    enable_i <= 1'b0;
  endtask

  task automatic drain_pipe();
    go_idle();
    while (exp_q.size() > 0) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_ok++;
      $display("test %s: passed", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // result checker, samples between edges
  always @(negedge clk) begin : result_monitor
    exp_t e;
    if (rst_n_i) begin
      if (result_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("unexpected result_valid_o pulse at %0t with nothing in flight", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          if (e.due != cyc) begin
            $display("result at %0t came at cycle %0d instead of %0d", $time, cyc, e.due);
            errors++;
          end
          compare_word(result_o, e.res, $sformatf("%s %s result", e.op.name(), e.mode.name()));
          if (e.chk_cmp) begin
            compare_word({31'b0, comparison_result_o}, {31'b0, e.cmp},
                         $sformatf("%s %s comparison_result_o", e.op.name(), e.mode.name()));
          end
        end
      end else if (exp_q.size() > 0 && exp_q[0].due <= cyc) begin
        $display("missing result_valid_o pulse at %0t for %s", $time, exp_q[0].op.name());
        errors++;
        void'(exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic arith_ops();
    word_t ea [4];
    word_t eb [4];
    word_t a;
    word_t b;
    int    err0;
    err0 = errors;
    // carries that would cross lane borders
    ea = '{32'hFFFF_FFFF, 32'h7FFF_7FFF, 32'h8080_8080, 32'h0000_0000};
    eb = '{32'h0000_0001, 32'h0001_0001, 32'h8080_8080, 32'h0000_0001};
    for (int m = 0; m < 3; m++) begin
      for (int k = 0; k < 8; k++) begin
        a = (k < 4) ? ea[k] : rnd_word();
        b = (k < 4) ? eb[k] : rnd_word();
        issue_op(ALU_ADD, pick_mode(m), a, b);
        issue_op(ALU_SUB, pick_mode(m), a, b);
      end
    end
    drain_pipe();
    report_test("add_sub", err0);
  endtask

  task automatic logic_ops();
    word_t a;
    word_t b;
    int    err0;
    err0 = errors;
    for (int k = 0; k < 8; k++) begin
      a = rnd_word();
      b = rnd_word();
      issue_op(ALU_AND, pick_mode(k), a, b);
      issue_op(ALU_OR, pick_mode(k), a, b);
      issue_op(ALU_XOR, pick_mode(k), a, b);
    end
    drain_pipe();
    report_test("logic", err0);
  endtask

  task automatic shift_ops();
    alu_op_e ops [4];
    word_t   a;
    word_t   b;
    int      err0;
    err0 = errors;
    ops  = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR};
    for (int m = 0; m < 3; m++) begin
      for (int k = 0; k < 7; k++) begin
        // zero amount on a lone sign bit, then mixed per-lane amounts
        a = (k == 0) ? 32'h8000_0000 : (k == 1) ? 32'hF00F_80FF : rnd_word();
        b = (k == 0) ? 32'h0000_0000 : (k == 1) ? 32'h1F0F_0701 : rnd_word();
        for (int o = 0; o < 4; o++) begin
          issue_op(ops[o], pick_mode(m), a, b);
        end
      end
    end
    drain_pipe();
    report_test("shift", err0);
  endtask

  task automatic compare_ops();
    word_t a;
    word_t b;
    int    err0;
    err0 = errors;
    for (int m = 0; m < 3; m++) begin
      for (int k = 0; k < 6; k++) begin
        a = rnd_word();
        case (k)
          0:       b = a;
          1:       b = a ^ 32'h0000_0080;
          2: begin
            a = 32'h8000_0000;
            b = 32'h7FFF_FFFF;
          end
          3: begin
            a = 32'h7F80_017F;
            b = 32'h807F_7F80;
          end
          default: b = rnd_word();
        endcase
        for (int o = int'(ALU_EQ); o <= int'(ALU_SLTU); o++) begin
          issue_op(alu_op_e'(o), pick_mode(m), a, b);
        end
      end
    end
    drain_pipe();
    report_test("compare", err0);
  endtask

  task automatic minmax_ops();
    word_t a;
    word_t b;
    int    err0;
    err0 = errors;
    for (int m = 0; m < 3; m++) begin
      for (int k = 0; k < 5; k++) begin
        // negative lanes split signed from unsigned
        a = (k == 0) ? 32'h80FF_7F01 : rnd_word();
        b = (k == 0) ? 32'h017F_80FF : (k == 1) ? a : rnd_word();
        for (int o = int'(ALU_MIN); o <= int'(ALU_MAXU); o++) begin
          issue_op(alu_op_e'(o), pick_mode(m), a, b);
        end
      end
    end
    drain_pipe();
    report_test("min_max", err0);
  endtask

  task automatic back_to_back_stream();
    int err0;
    err0 = errors;
    // random ops with the odd idle cycle between them
    for (int k = 0; k < 40; k++) begin
      if ($unsigned($random(seed)) % 4 == 0) begin
        go_idle();
      end
      issue_op(alu_op_e'($unsigned($random(seed)) % 25), pick_mode($unsigned($random(seed))),
               rnd_word(), rnd_word());
    end
    drain_pipe();
    report_test("pipeline", err0);
  endtask

  task automatic reset_mid_stream();
    int err0;
    err0 = errors;
    for (int k = 0; k < 3; k++) begin
      issue_op(ALU_ADD, VEC_MODE32, rnd_word(), rnd_word());
    end
    // enable_i stays high into the one reset cycle so every stage has an op to drop
    @(posedge clk);
    rst_n_i <= 1'b0;
    exp_q.delete();
    @(posedge clk);
    rst_n_i  <= 1'b1;
    enable_i <= 1'b0;
    repeat (6) begin
      @(negedge clk);
      checks++;
      if (result_valid_o !== 1'b0) begin
        $display("result_valid_o high at %0t after reset with nothing issued", $time);
        errors++;
      end
    end
    for (int k = 0; k < 4; k++) begin
      issue_op(alu_op_e'($unsigned($random(seed)) % 25), pick_mode(k), rnd_word(), rnd_word());
    end
    drain_pipe();
    report_test("reset", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    enable_i      = 1'b0;
    operator_i    = ALU_ADD;
    vector_mode_i = VEC_MODE32;
    operand_a_i   = '0;
    operand_b_i   = '0;
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    arith_ops();
    logic_ops();
    shift_ops();
    compare_ops();
    minmax_ops();
    back_to_back_stream();
    reset_mid_stream();
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
